/* mk14_stimulus.txt */
# Commands: hex <chars> | wr <addr> <data> | rd <addr> <expected> | frame <bytes of digits 0..7>
# err <code> | state <rx_wait> <core_en> | wait_run | quiet <decimal cycles> | reset
quiet 100
state 1 0
err 0
hex :03010000a55ac33A
hex :080D00003F065B4F666D7D07A5
hex :00000001FF
wait_run
state 0 1
err 0
rd 0100 A5
rd 0101 5A
rd 0102 C3
rd 1100 A5
frame 3F 06 5B 4F 66 6D 7D 07
wr 0D03 79
frame 3F 06 5B 79 66 6D 7D 07
wr 0200 5C
rd 0200 5C
hex :0101000000FE
rd 0100 A5
state 0 1
reset
state 1 0
err 0
hex :0101000000FF
err 2
state 1 0
reset
hex :01G
err 1
reset
hex :00000002FE
err 3
state 1 0

/* tb.f */
mk14_pkg.sv
ihex_pkg.sv
intel_hex.sv
mmu.sv
display_scan.sv
mk14_soc.sv
mk14_soc_properties.sv
tb_mk14_soc.sv

/* tb_mk14_soc.sv */
// Testbench for the SoC: stimulus file reader, byte stream and CPU bus drivers, result checks.
module tb_mk14_soc;

	localparam int clk_period = 10;
	localparam int frame_wait_limit = 200;
	localparam int run_wait_limit = 20;
	localparam stim_file = "mk14_stimulus.txt";

	logic clk;
	logic soft_reset;
	logic [7:0] rx_data;
	logic rx_valid;
	mk14_pkg::mem_bus_t cpu_bus;
	logic [7:0] cpu_rdata;
	logic core_en;
	logic rx_wait;
	ihex_pkg::ihex_err_e load_error;
	mk14_pkg::seg7_t seg7;

	integer seed;
	integer fd;
	int mismatch_count = 0;
	int failure_count = 0;
	int stim_lines = 0;
	bit stim_counted = 0;
	reg [8*256-1:0] line;
	logic [7:0] frame_expect [8];	// Segment bytes of digits 0 to 7.

	mk14_soc #(
		.MEM_ADDR_BITS(12),
		.REFRESH_CYCLES(20)
	) dut_i (
		.clk,
		.soft_reset,
		.i_rx_data(rx_data),
		.i_rx_valid(rx_valid),
		.i_cpu_bus(cpu_bus),
		.o_cpu_rdata(cpu_rdata),
		.o_core_en(core_en),
		.o_rx_wait(rx_wait),
		.o_load_error(load_error),
		.o_seg7(seg7)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			mismatch_count++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at time %0t",
				name, actual, expected, $time);
		end
	endtask

	task automatic report_failure(input string what);
		failure_count++;
		$display("Error: %s at time %0t", what, $time);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		soft_reset <= 1'b1;
		repeat (8) @(posedge clk);
		soft_reset <= 1'b0;
	endtask

	// One strobe per character, then a short random idle gap.
	task automatic send_char(input logic [7:0] c);
		int gap;
		@(posedge clk);
		rx_data <= c;
		rx_valid <= 1'b1;
		@(posedge clk);
		rx_valid <= 1'b0;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(posedge clk);
	endtask

	// Tokens from $fscanf are right aligned, so leading zero bytes are skipped.
	task automatic send_text(input reg [8*64-1:0] text);
		int i;
		for (i = 63; i >= 0; i--) begin
			if (text[i*8 +: 8] != 8'h00)
				send_char(text[i*8 +: 8]);
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_bus.addr <= addr;
		cpu_bus.wdata <= data;
		cpu_bus.write_en <= 1'b1;
		@(posedge clk);
		cpu_bus.write_en <= 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, input logic [7:0] expected);
		@(posedge clk);
		cpu_bus.addr <= addr;
		cpu_bus.write_en <= 1'b0;
		@(posedge clk);	// Read data is registered by the memory.
		@(negedge clk);
		check_value("o_cpu_rdata", cpu_rdata, expected);
	endtask

	task automatic wait_for_run();
		int waited;
		bit found;
		found = 0;
		for (waited = 0; waited < run_wait_limit && !found; waited++) begin
			@(negedge clk);
			found = core_en;
		end
		if (!found)
			report_failure("the core was not enabled after the end of file record");
	endtask

	task automatic check_frame();
		int waited;
		int k;
		bit found;
		found = 0;
		for (waited = 0; waited < frame_wait_limit && !found; waited++) begin
			@(negedge clk);
			found = seg7.valid && (seg7.digit == 3'd0);
		end
		if (!found) begin
			report_failure("no display frame started within the wait limit");
		end else begin
			for (k = 0; k < 8; k++) begin
				check_value("o_seg7.valid", seg7.valid, 1'b1);
				check_value("o_seg7.digit", seg7.digit, k);
				check_value("o_seg7.segments", seg7.segments, frame_expect[k]);
				@(negedge clk);
			end
		end
	endtask

	task automatic expect_no_strobe(input int cycles);
		int n;
		bit seen;
		seen = 0;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (seg7.valid)
				seen = 1;
		end
		if (seen)
			report_failure("a display strobe appeared while no scan was expected");
	endtask

	task automatic count_stim_lines();
		integer cfd;
		integer r;
		cfd = $fopen(stim_file, "r");
		if (cfd != 0) begin
			while (!$feof(cfd)) begin
				r = $fgets(line, cfd);
				if (r != 0)
					stim_lines++;
			end
			$fclose(cfd);
		end
		stim_counted = 1;
	endtask

	task automatic run_commands();
		reg [8*16-1:0] cmd;
		reg [8*64-1:0] text;
		logic [31:0] a;
		logic [31:0] b;
		integer r;
		int k;
		bit done;
		done = 0;
		while (!done) begin
			r = $fscanf(fd, "%s", cmd);
			if (r != 1) begin
				done = 1;
			end else if (cmd == "#") begin
				r = $fgets(line, fd);
			end else if (cmd == "hex") begin
				r = $fscanf(fd, "%s", text);
				send_text(text);
			end else if (cmd == "wr") begin
				r = $fscanf(fd, "%h %h", a, b);
				cpu_write(a[15:0], b[7:0]);
			end else if (cmd == "rd") begin
				r = $fscanf(fd, "%h %h", a, b);
				cpu_read(a[15:0], b[7:0]);
			end else if (cmd == "frame") begin
				for (k = 0; k < 8; k++) begin
					r = $fscanf(fd, "%h", a);
					frame_expect[k] = a[7:0];
				end
				check_frame();
			end else if (cmd == "err") begin
				r = $fscanf(fd, "%h", a);
				@(negedge clk);
				check_value("o_load_error", load_error, a);
			end else if (cmd == "state") begin
				r = $fscanf(fd, "%h %h", a, b);
				@(negedge clk);
				check_value("o_rx_wait", rx_wait, a);
				check_value("o_core_en", core_en, b);
			end else if (cmd == "wait_run") begin
				wait_for_run();
			end else if (cmd == "quiet") begin
				r = $fscanf(fd, "%d", a);
				expect_no_strobe(a);
			end else if (cmd == "reset") begin
				apply_reset();
			end else begin
				report_failure("unknown command in the stimulus file");
				done = 1;
			end
		end
	endtask

	initial begin
		seed = 3720;
		soft_reset = 1'b1;
		rx_data = 8'h00;
		rx_valid = 1'b0;
		cpu_bus = '0;
		count_stim_lines();
		fd = $fopen(stim_file, "r");
		if (fd == 0) begin
			report_failure("the stimulus file could not be opened");
		end else begin
			repeat (8) @(posedge clk);
			soft_reset <= 1'b0;
			run_commands();
			$fclose(fd);
		end
		repeat (5) @(posedge clk);
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, failure_count, dut_i.props_i.fail_count);
		if (mismatch_count + failure_count + dut_i.props_i.fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Limit grows with the length of the stimulus file.
	initial begin
		wait (stim_counted);
		repeat (stim_lines * 200 + 1000) @(posedge clk);
		$display("Timeout: the test did not finish within %0d cycles", stim_lines * 200 + 1000);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* mk14_soc_properties.sv */
// Concurrent assertions on the SoC load/run control and display strobes, bound to mk14_soc.
module mk14_soc_properties (
	input logic clk,
	input logic soft_reset,
	input logic i_core_en,
	input logic i_rx_wait,
	input mk14_pkg::seg7_t i_seg7
);

	int fail_count = 0;

	// The CPU never runs while the loader still owns memory.
	core_rx_exclusive: assert property (@(posedge clk) disable iff (soft_reset)
		!(i_core_en && i_rx_wait))
		else begin
			fail_count++;
			$error("core enable and load wait are high together");
		end

	seg7_only_running: assert property (@(posedge clk) disable iff (soft_reset)
		i_seg7.valid |-> i_core_en)
		else begin
			fail_count++;
			$error("display strobe while the core is disabled");
		end

	quiet_after_reset: assert property (@(posedge clk)
		soft_reset |=> (!i_core_en && !i_seg7.valid))
		else begin
			fail_count++;
			$error("core enable or display strobe high right after reset");
		end

endmodule

bind mk14_soc mk14_soc_properties props_i (
	.clk,
	.soft_reset,
	.i_core_en(o_core_en),
	.i_rx_wait(o_rx_wait),
	.i_seg7(o_seg7)
);

/* mk14_soc.sv */
// SoC top level with load/run control, display refresh timer and memory bus multiplexer.
module mk14_soc #(
	parameter int MEM_ADDR_BITS = 12,
	parameter int REFRESH_CYCLES = 64
) (
	input logic clk,
	input logic soft_reset,
	input logic [7:0] i_rx_data,
	input logic i_rx_valid,
	input mk14_pkg::mem_bus_t i_cpu_bus,
	output logic [7:0] o_cpu_rdata,
	output logic o_core_en,
	output logic o_rx_wait,
	output ihex_pkg::ihex_err_e o_load_error,
	output mk14_pkg::seg7_t o_seg7
);

	localparam int refresh_bits = $clog2(REFRESH_CYCLES + 1);
	localparam logic [refresh_bits-1:0] refresh_reload = refresh_bits'(REFRESH_CYCLES);

	mk14_pkg::soc_state_e state;
	mk14_pkg::mem_bus_t loader_bus;
	mk14_pkg::mem_bus_t mem_bus;
	logic parse_complete;
	logic [refresh_bits-1:0] refresh_count;
	logic scan_start;
	logic scan_idle;
	logic [15:0] disp_addr;
	logic [7:0] disp_data;

	assign o_rx_wait = state == mk14_pkg::rx_wait;
	assign o_core_en = state == mk14_pkg::running;

	// Received bytes only reach the loader while waiting for a program.
	intel_hex intel_hex_i (
		.clk,
		.soft_reset,
		.i_en(i_rx_valid && o_rx_wait),
		.i_data(i_rx_data),
		.o_wr(loader_bus),
		.o_parse_complete(parse_complete),
		.o_error(o_load_error)
	);

	always_comb begin
		case (state)
			mk14_pkg::rx_wait: mem_bus = loader_bus;
			mk14_pkg::running: mem_bus = i_cpu_bus;
			default: begin
				mem_bus = i_cpu_bus;
				mem_bus.write_en = 1'b0;	// Nobody writes during start.
			end
		endcase
	end

	mmu #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS)
	) mmu_i (
		.clk,
		.i_bus(mem_bus),
		.o_rdata(o_cpu_rdata),
		.i_disp_addr(disp_addr),
		.o_disp_rdata(disp_data)
	);

	display_scan display_scan_i (
		.clk,
		.soft_reset,
		.i_start(scan_start),
		.o_idle(scan_idle),
		.o_read_addr(disp_addr),
		.i_read_data(disp_data),
		.o_seg7
	);

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			state <= mk14_pkg::rx_wait;
		end else begin
			case (state)
				mk14_pkg::rx_wait:
					if (parse_complete)
						state <= mk14_pkg::start;
				mk14_pkg::start: state <= mk14_pkg::running;
				mk14_pkg::running: state <= mk14_pkg::running;
				default: state <= mk14_pkg::rx_wait;
			endcase
		end
	end

	// A scan starts when the count has expired and the previous scan is over.
	always_ff @(posedge clk) begin
		scan_start <= 1'b0;
		if (soft_reset) begin
			refresh_count <= refresh_reload;
		end else if (state == mk14_pkg::start) begin
			refresh_count <= refresh_reload;
		end else if (state == mk14_pkg::running) begin
			if (refresh_count != '0) begin
				refresh_count <= refresh_count - 1'b1;
			end else if (scan_idle) begin
				scan_start <= 1'b1;
				refresh_count <= refresh_reload;
			end
		end
	end

endmodule

/* display_scan.sv */
// Display scanner reading the seven-segment bytes and emitting one strobe per digit.
module display_scan (
	input logic clk,
	input logic soft_reset,
	input logic i_start,
	output logic o_idle,
	output logic [15:0] o_read_addr,
	input logic [7:0] i_read_data,
	output mk14_pkg::seg7_t o_seg7
);

	localparam logic [2:0] last_digit = 3'(mk14_pkg::seg7_count - 1);

	logic active;	// High while read addresses are being issued.
	logic [2:0] rd_idx;
	logic rd_valid_q;
	logic [2:0] rd_digit_q;

	assign o_read_addr = mk14_pkg::seg7_base_addr + {13'd0, rd_idx};

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			active <= 1'b0;
			rd_idx <= 3'd0;
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= active;
			if (active) begin
				if (rd_idx == last_digit)
					active <= 1'b0;
				rd_idx <= rd_idx + 3'd1;
			end else if (i_start) begin
				active <= 1'b1;
				rd_idx <= 3'd0;
			end
		end
	end

	// The digit index follows its read by one cycle to meet the memory data.
	always_ff @(posedge clk) begin
		rd_digit_q <= rd_idx;
	end

	assign o_idle = !active && !rd_valid_q;

	assign o_seg7.digit = rd_digit_q;
	assign o_seg7.segments = i_read_data;
	assign o_seg7.valid = rd_valid_q;

endmodule

/* mmu.sv */
// Shared byte memory with a read/write bus port and a read-only display port.
module mmu #(
	parameter int MEM_ADDR_BITS = 12
) (
	input logic clk,
	input mk14_pkg::mem_bus_t i_bus,
	output logic [7:0] o_rdata,
	input logic [15:0] i_disp_addr,
	output logic [7:0] o_disp_rdata
);

	localparam int mem_size = 2 ** MEM_ADDR_BITS;

	logic [7:0] mem [mem_size];
	logic [MEM_ADDR_BITS-1:0] bus_index;
	logic [MEM_ADDR_BITS-1:0] disp_index;

	// Upper address bits are dropped, so addresses wrap around the array.
	assign bus_index = i_bus.addr[MEM_ADDR_BITS-1:0];
	assign disp_index = i_disp_addr[MEM_ADDR_BITS-1:0];

	always_ff @(posedge clk) begin
		if (i_bus.write_en)
			mem[bus_index] <= i_bus.wdata;
		o_rdata <= mem[bus_index];	// Old contents on a write cycle.
	end

	always_ff @(posedge clk) begin
		o_disp_rdata <= mem[disp_index];
	end

endmodule

/* intel_hex.sv */
// Streaming Intel HEX parser producing memory writes, completion pulse and sticky error.
module intel_hex (
	input logic clk,
	input logic soft_reset,
	input logic i_en,
	input logic [7:0] i_data,
	output mk14_pkg::mem_bus_t o_wr,
	output logic o_parse_complete,
	output ihex_pkg::ihex_err_e o_error
);

	ihex_pkg::ihex_state_e state;
	ihex_pkg::ihex_type_e rec_type;
	logic [7:0] byte_count;	// Data bytes still expected in this record.
	logic [15:0] addr;
	logic [7:0] sum;
	logic [3:0] hi_nibble;
	logic second_char;	// High while the low nibble of a byte is expected.

	logic [4:0] decoded;
	logic char_ok;
	logic [7:0] byte_val;
	logic [7:0] sum_next;

	// Returns a valid flag above the nibble value of one ASCII hex character.
	function automatic logic [4:0] hex_decode(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, 4'(c - "0")};
		else if (c >= "A" && c <= "F")
			r = {1'b1, 4'(c - "A" + 8'd10)};
		else if (c >= "a" && c <= "f")
			r = {1'b1, 4'(c - "a" + 8'd10)};
		return r;
	endfunction

	assign decoded = hex_decode(i_data);
	assign char_ok = decoded[4];
	assign byte_val = {hi_nibble, decoded[3:0]};
	assign sum_next = sum + byte_val;

	always_ff @(posedge clk) begin
		o_wr.write_en <= 1'b0;
		o_parse_complete <= 1'b0;
		if (soft_reset) begin
			state <= ihex_pkg::idle;
			o_error <= ihex_pkg::err_none;
			second_char <= 1'b0;
		end else if (i_en) begin
			if (state == ihex_pkg::idle) begin
				// Anything before the start code, line ends included, is skipped.
				if (i_data == ":") begin
					state <= ihex_pkg::count;
					sum <= 8'd0;
					second_char <= 1'b0;
				end
			end else if (state != ihex_pkg::done) begin
				if (!char_ok) begin
					if (o_error == ihex_pkg::err_none)
						o_error <= ihex_pkg::err_bad_char;
					state <= ihex_pkg::idle;
				end else if (!second_char) begin
					hi_nibble <= decoded[3:0];
					second_char <= 1'b1;
				end else begin
					second_char <= 1'b0;
					sum <= sum_next;
					case (state)
						ihex_pkg::count: begin
							byte_count <= byte_val;
							state <= ihex_pkg::addr_hi;
						end
						ihex_pkg::addr_hi: begin
							addr[15:8] <= byte_val;
							state <= ihex_pkg::addr_lo;
						end
						ihex_pkg::addr_lo: begin
							addr[7:0] <= byte_val;
							state <= ihex_pkg::rtype;
						end
						ihex_pkg::rtype: begin
							if (byte_val == ihex_pkg::rec_data || byte_val == ihex_pkg::rec_eof) begin
								rec_type <= ihex_pkg::ihex_type_e'(byte_val);
								state <= (byte_count == 8'd0) ? ihex_pkg::checksum : ihex_pkg::data;
							end else begin
								if (o_error == ihex_pkg::err_none)
									o_error <= ihex_pkg::err_type;
								state <= ihex_pkg::idle;
							end
						end
						ihex_pkg::data: begin
							// Bytes go to memory as they arrive, before the checksum is known.
							if (rec_type == ihex_pkg::rec_data) begin
								o_wr.write_en <= 1'b1;
								o_wr.addr <= addr;
								o_wr.wdata <= byte_val;
							end
							addr <= addr + 16'd1;
							byte_count <= byte_count - 8'd1;
							if (byte_count == 8'd1)
								state <= ihex_pkg::checksum;
						end
						ihex_pkg::checksum: begin
							if (sum_next != 8'd0) begin
								if (o_error == ihex_pkg::err_none)
									o_error <= ihex_pkg::err_checksum;
								state <= ihex_pkg::idle;
							end else if (rec_type == ihex_pkg::rec_eof) begin
								o_parse_complete <= 1'b1;
								state <= ihex_pkg::done;
							end else begin
								state <= ihex_pkg::idle;
							end
						end
						default: state <= ihex_pkg::idle;
					endcase
				end
			end
		end
	end

endmodule

/* ihex_pkg.sv */
// Intel HEX record types, parser states and loader error codes.
package ihex_pkg;

	// Only data and end-of-file records are accepted.
	typedef enum logic [7:0] {
		rec_data = 8'h00,
		rec_eof = 8'h01
	} ihex_type_e;

	typedef enum logic [2:0] {
		idle,
		count,
		addr_hi,
		addr_lo,
		rtype,
		data,
		checksum,
		done
	} ihex_state_e;

	typedef enum logic [1:0] {
		err_none,
		err_bad_char,
		err_checksum,
		err_type
	} ihex_err_e;

endpackage

/* mk14_pkg.sv */
// Memory map constants, memory bus and display strobe structs, SoC control states.
package mk14_pkg;

	// The display digits live at consecutive addresses starting here.
	localparam logic [15:0] seg7_base_addr = 16'hD00;
	localparam int seg7_count = 8;

	// Used by the HEX loader and by the CPU port alike.
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic write_en;
	} mem_bus_t;

	// One strobe per digit, segments as stored in memory.
	typedef struct packed {
		logic [2:0] digit;
		logic [7:0] segments;
		logic valid;
	} seg7_t;

	typedef enum logic [1:0] {
		rx_wait = 2'd0,	// Waiting for a program to be loaded.
		start = 2'd1,
		running = 2'd2
	} soc_state_e;

endpackage
